// ==== vlog.f ====
hw/nbr_pkg.sv
hw/nbr_req_fifo.sv
hw/nbr_mem_ctrl.sv
hw/nbr_sram.sv
hw/nbr_bank_ctrl.sv
hw/nbr_pe_bus.sv
hw/nbr_fetch_top.sv
verif/nbr_fetch_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := nbr_fetch_tb
RTL_TOP    := nbr_fetch_top
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/nbr_fetch_tb.sv ====
`timescale 1ns/1ps

module nbr_fetch_tb;
    import nbr_pkg::*;

    localparam int N_RAND         = 60;
    localparam int N_BURST        = 12;
    localparam int MAX_CNT        = 2**CNT_W - 1;
    localparam int TAG_W          = ID_W - BANK_W - ADDR_W;
    localparam int PEND_DEPTH     = 128;
    // reset and load phase, then every frame at worst length, plus margin
    localparam int TIMEOUT_CYCLES = 16 + NUM_BANKS * BANK_DEPTH
                                  + (N_RAND + N_BURST) * (2 * MAX_CNT + 1) + 500;

    logic                    clk;
    logic                    rst_n;
    logic                    req_valid;
    nbr_req_t                req;
    nbr_load_t               load;
    logic                    req_full;
    pe_stream_t [NUM_PE-1:0] pe_out;

    logic [ID_W-1:0]   ref_mem [NUM_BANKS*BANK_DEPTH];   // index is {bank, addr}
    logic [ADDR_W-1:0] pend_start [NUM_PE][NUM_BANKS][PEND_DEPTH];
    logic [CNT_W-1:0]  pend_count [NUM_PE][NUM_BANKS][PEND_DEPTH];
    int                wr_idx [NUM_PE][NUM_BANKS];
    int                rd_idx [NUM_PE][NUM_BANKS];
    int                acc_cnt [NUM_PE];
    int                eos_cnt [NUM_PE];
    int                cycle = 0;
    logic              saw_full;
    logic              burst_phase;

    logic [NUM_PE-1:0] in_frame;
    logic [CNT_W-1:0]  frame_cnt [NUM_PE];
    logic [BANK_W-1:0] frame_bank [NUM_PE];
    logic [CNT_W-1:0]  next_iter [NUM_PE];
    logic [ADDR_W-1:0] next_addr [NUM_PE];
    logic [BANK_W-1:0] beat_bank [NUM_PE];
    logic [ID_W-1:0]   exp_id [NUM_PE];
    logic [ADDR_W-1:0] head_start [NUM_PE];
    logic [CNT_W-1:0]  exp_count [NUM_PE];
    logic [NUM_PE-1:0] has_pend;
    logic [NUM_PE-1:0] pe_valid;

    nbr_fetch_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .load      (load),
        .req_full  (req_full),
        .pe_out    (pe_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #10;
        req_valid = 1'b0;
        load      = '0;
    endtask

    task automatic load_word(input int bank, input int addr, input logic [ID_W-1:0] id);
        @(posedge clk);
        #10;
        req_valid = 1'b0;
        load      = '{valid: 1'b1, bank: BANK_W'(bank), addr: ADDR_W'(addr), id: id};
        ref_mem[bank * BANK_DEPTH + addr] = id;
    endtask

    // holds off while full unless the overflow is wanted
    task automatic send_req(input nbr_req_t r, input logic wait_room);
        @(posedge clk);
        #10;
        load = '0;
        while (wait_room && req_full) begin
            req_valid = 1'b0;
            @(posedge clk);
            #10;
        end
        req_valid = 1'b1;
        req       = r;
    endtask

    // expected values for the beat now on each pe_out
    always_comb begin
        for (int p = 0; p < NUM_PE; p++) begin
            beat_bank[p]  = pe_out[p].id[ADDR_W +: BANK_W];
            exp_id[p]     = ref_mem[pe_out[p].id[BANK_W+ADDR_W-1:0]];
            has_pend[p]   = rd_idx[p][beat_bank[p]] != wr_idx[p][beat_bank[p]];
            head_start[p] = pend_start[p][beat_bank[p]][rd_idx[p][beat_bank[p]]];
            exp_count[p]  = in_frame[p] ? frame_cnt[p]
                                        : pend_count[p][beat_bank[p]][rd_idx[p][beat_bank[p]]];
            pe_valid[p]   = pe_out[p].valid;
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            saw_full <= 1'b0;
            for (int p = 0; p < NUM_PE; p++) begin
                acc_cnt[p] <= 0;
                for (int b = 0; b < NUM_BANKS; b++) begin
                    wr_idx[p][b] <= 0;
                end
            end
        end else begin
            if (req_valid && !req_full) begin   // taken by the FIFO
                pend_start[req.pe_tag][req.bank][wr_idx[req.pe_tag][req.bank]] <= req.start;
                pend_count[req.pe_tag][req.bank][wr_idx[req.pe_tag][req.bank]] <= req.count;
                wr_idx[req.pe_tag][req.bank] <= (wr_idx[req.pe_tag][req.bank] + 1) % PEND_DEPTH;
                acc_cnt[req.pe_tag] <= acc_cnt[req.pe_tag] + 1;
            end
            if (burst_phase && req_full) begin
                saw_full <= 1'b1;
            end
        end
    end

    // per PE frame tracking, a bank serves its own requests in order
    always @(posedge clk) begin
        if (!rst_n) begin
            in_frame <= '0;
            for (int p = 0; p < NUM_PE; p++) begin
                eos_cnt[p] <= 0;
                for (int b = 0; b < NUM_BANKS; b++) begin
                    rd_idx[p][b] <= 0;
                end
            end
        end else begin
            for (int p = 0; p < NUM_PE; p++) begin
                if (pe_out[p].valid) begin
                    if (!in_frame[p]) begin
                        frame_cnt[p]  <= exp_count[p];
                        frame_bank[p] <= beat_bank[p];
                        rd_idx[p][beat_bank[p]] <= (rd_idx[p][beat_bank[p]] + 1) % PEND_DEPTH;
                    end
                    in_frame[p]  <= !pe_out[p].eos;
                    next_iter[p] <= pe_out[p].iter + CNT_W'(1);
                    next_addr[p] <= pe_out[p].id[ADDR_W-1:0] + ADDR_W'(1);
                    if (pe_out[p].eos) begin
                        eos_cnt[p] <= eos_cnt[p] + 1;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout after %0d cycles with frames still outstanding", cycle));
        end
    end

    for (genvar p = 0; p < NUM_PE; p++) begin : g_chk
        a_id: assert property (@(posedge clk) disable iff (!rst_n)
            pe_out[p].valid |-> pe_out[p].id == exp_id[p])
            else fail_run($sformatf("mismatch pe%0d id: got %h expected %h",
                                    p, $sampled(pe_out[p].id), $sampled(exp_id[p])));
        a_first: assert property (@(posedge clk) disable iff (!rst_n)
            (pe_out[p].valid && !in_frame[p]) |-> (pe_out[p].sos && pe_out[p].iter == '0))
            else fail_run($sformatf("pe%0d frame did not open with sos at iter 0", p));
        a_start: assert property (@(posedge clk) disable iff (!rst_n)
            (pe_out[p].valid && !in_frame[p])
                |-> (has_pend[p] && pe_out[p].id[ADDR_W-1:0] == head_start[p]))
            else fail_run($sformatf("mismatch pe%0d start addr: got %h expected %h", p,
                                    $sampled(pe_out[p].id[ADDR_W-1:0]), $sampled(head_start[p])));
        a_next_iter: assert property (@(posedge clk) disable iff (!rst_n)
            (pe_out[p].valid && in_frame[p]) |-> (!pe_out[p].sos && pe_out[p].iter == next_iter[p]))
            else fail_run($sformatf("mismatch pe%0d iter: got %h expected %h", p,
                                    $sampled(pe_out[p].iter), $sampled(next_iter[p])));
        a_next_addr: assert property (@(posedge clk) disable iff (!rst_n)
            (pe_out[p].valid && in_frame[p])
                |-> (beat_bank[p] == frame_bank[p] && pe_out[p].id[ADDR_W-1:0] == next_addr[p]))
            else fail_run($sformatf("mismatch pe%0d addr: got %h expected %h", p,
                                    $sampled(pe_out[p].id[BANK_W+ADDR_W-1:0]),
                                    $sampled({frame_bank[p], next_addr[p]})));
        a_eos: assert property (@(posedge clk) disable iff (!rst_n)
            pe_out[p].valid |-> (pe_out[p].eos == (pe_out[p].iter == exp_count[p] - CNT_W'(1))))
            else fail_run($sformatf("mismatch pe%0d eos: got %h expected %h", p,
                                    $sampled(pe_out[p].eos),
                                    $sampled(pe_out[p].iter == exp_count[p] - CNT_W'(1))));
    end

    a_reset_quiet: assert property (@(posedge clk)
        (cycle != 0 && (!rst_n || !$past(rst_n))) |-> (!req_full && pe_valid == '0))
        else fail_run("req_full or a pe_out valid was high in or right after reset");

    initial begin
        nbr_req_t r;
        int       a;
        int       pending;
        int       bad_pe;

        void'($urandom(32'hc623_6bd2));
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        load        = '0;
        burst_phase = 1'b0;
        repeat (16) @(posedge clk);
        #10;
        rst_n = 1'b1;

        // low bits of each id carry its own bank and address
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int w = 0; w < BANK_DEPTH; w++) begin
                load_word(b, w, {TAG_W'($urandom), BANK_W'(b), ADDR_W'(w)});
            end
        end
        idle_cycle();

        for (int i = 0; i < N_RAND; i++) begin
            r.bank   = BANK_W'($urandom_range(NUM_BANKS - 1));
            r.count  = CNT_W'($urandom_range(MAX_CNT, 1));
            r.start  = ADDR_W'($urandom_range(BANK_DEPTH - int'(r.count)));
            r.pe_tag = PE_W'($urandom_range(NUM_PE - 1));
            send_req(r, 1'b1);
            if ($urandom_range(3) == 0) begin   // same-value rewrite steals a read slot
                a    = $urandom_range(NUM_BANKS * BANK_DEPTH - 1);
                load = '{valid: 1'b1, bank: BANK_W'(a / BANK_DEPTH),
                         addr: ADDR_W'(a % BANK_DEPTH), id: ref_mem[a]};
            end
            repeat ($urandom_range(2)) idle_cycle();
        end

        burst_phase = 1'b1;
        for (int i = 0; i < N_BURST; i++) begin
            r.bank   = '0;
            r.count  = CNT_W'(MAX_CNT);
            r.start  = ADDR_W'($urandom_range(BANK_DEPTH - MAX_CNT));
            r.pe_tag = PE_W'($urandom_range(NUM_PE - 1));
            send_req(r, 1'b0);
        end
        idle_cycle();
        burst_phase = 1'b0;

        do begin
            idle_cycle();
            pending = 0;
            for (int p = 0; p < NUM_PE; p++) begin
                pending += acc_cnt[p] - eos_cnt[p];
            end
        end while (pending != 0);
        repeat (20) idle_cycle();   // any stray frame shows up here

        bad_pe = -1;
        for (int p = 0; p < NUM_PE; p++) begin
            if (eos_cnt[p] != acc_cnt[p]) begin
                bad_pe = p;
            end
        end
        if (saw_full && bad_pe < 0) begin
            $display("Result: PASSED");
            $finish;
        end else if (!saw_full) begin
            fail_run("request FIFO never went full during the burst");
        end else begin
            fail_run($sformatf("mismatch pe%0d eos count: got %h expected %h",
                               bad_pe, eos_cnt[bad_pe], acc_cnt[bad_pe]));
        end
    end

endmodule

// ==== hw/nbr_fetch_top.sv ====
`timescale 1ns/1ps

module nbr_fetch_top (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       req_valid,
    input  nbr_pkg::nbr_req_t                          req,
    input  nbr_pkg::nbr_load_t                         load,
    output logic                                       req_full,
    output nbr_pkg::pe_stream_t [nbr_pkg::NUM_PE-1:0]  pe_out
);
    import nbr_pkg::*;

    nbr_req_t                  head;
    logic                      fifo_empty;
    logic                      fifo_pop;
    logic                      fifo_push;
    nbr_req_t [NUM_BANKS-1:0]   dispatch;
    logic [NUM_BANKS-1:0]       start;
    logic [NUM_BANKS-1:0]       bank_busy;
    logic [NUM_BANKS-1:0]       grant;
    bank_beat_t [NUM_BANKS-1:0] beats;

    assign fifo_push = req_valid && !req_full;   // drop while full

    nbr_req_fifo u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (fifo_push),
        .din   (req),
        .pop   (fifo_pop),
        .head  (head),
        .empty (fifo_empty),
        .full  (req_full)
    );

    nbr_mem_ctrl u_mem_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .head      (head),
        .empty     (fifo_empty),
        .bank_busy (bank_busy),
        .pop       (fifo_pop),
        .dispatch  (dispatch),
        .start     (start)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        nbr_bank_ctrl #(.BANK_IDX(b)) u_bank (
            .clk      (clk),
            .rst_n    (rst_n),
            .dispatch (dispatch[b]),
            .start    (start[b]),
            .load     (load),
            .grant    (grant[b]),
            .beat     (beats[b]),
            .busy     (bank_busy[b])
        );
    end

    nbr_pe_bus u_bus (
        .clk    (clk),
        .rst_n  (rst_n),
        .beats  (beats),
        .grant  (grant),
        .pe_out (pe_out)
    );

endmodule

// ==== hw/nbr_pe_bus.sv ====
`timescale 1ns/1ps

module nbr_pe_bus (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  nbr_pkg::bank_beat_t [nbr_pkg::NUM_BANKS-1:0]     beats,
    output logic [nbr_pkg::NUM_BANKS-1:0]                    grant,
    output nbr_pkg::pe_stream_t [nbr_pkg::NUM_PE-1:0]        pe_out
);
    import nbr_pkg::*;

    logic [NUM_PE-1:0]                 lock_valid;
    logic [NUM_PE-1:0][BANK_W-1:0]     lock_bank;
    logic [NUM_PE-1:0]                 sel_valid;
    logic [NUM_PE-1:0][BANK_W-1:0]     sel_bank;
    bank_beat_t [NUM_PE-1:0]           sel_beat;
    logic [NUM_BANKS-1:0][NUM_PE-1:0]  grant_by;

    always_comb begin
        grant_by = '0;
        for (int p = 0; p < NUM_PE; p++) begin
            sel_valid[p] = 1'b0;
            sel_bank[p]  = lock_bank[p];
            if (lock_valid[p]) begin
                sel_valid[p] = beats[lock_bank[p]].valid;
            end else begin
                // walk down so the lowest matching bank wins
                for (int b = NUM_BANKS - 1; b >= 0; b--) begin
                    if (beats[b].valid && beats[b].sos && beats[b].pe_tag == PE_W'(p)) begin
                        sel_valid[p] = 1'b1;
                        sel_bank[p]  = BANK_W'(b);
                    end
                end
            end
            sel_beat[p] = beats[sel_bank[p]];
            if (sel_valid[p]) begin
                grant_by[sel_bank[p]][p] = 1'b1;
            end
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            grant[b] = |grant_by[b];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lock_valid <= '0;
            lock_bank  <= '0;
            pe_out     <= '0;
        end else begin
            for (int p = 0; p < NUM_PE; p++) begin
                pe_out[p].valid <= sel_valid[p];
                if (sel_valid[p]) begin
                    pe_out[p].sos  <= sel_beat[p].sos;
                    pe_out[p].eos  <= sel_beat[p].eos;
                    pe_out[p].iter <= sel_beat[p].iter;
                    pe_out[p].id   <= sel_beat[p].id;
                    lock_valid[p]  <= !sel_beat[p].eos;   // single-beat frames never lock
                    lock_bank[p]   <= sel_bank[p];
                end
            end
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_chk
        a_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(grant_by[b]))
            else $error("bank %0d granted to more than one PE", b);
    end

endmodule

// ==== hw/nbr_bank_ctrl.sv ====
`timescale 1ns/1ps

module nbr_bank_ctrl #(
    parameter int BANK_IDX = 0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  nbr_pkg::nbr_req_t   dispatch,
    input  logic                start,
    input  nbr_pkg::nbr_load_t  load,
    input  logic                grant,
    output nbr_pkg::bank_beat_t beat,
    output logic                busy
);
    import nbr_pkg::*;

    bank_state_e       state;
    nbr_req_t          req_q;
    logic [ADDR_W-1:0] rd_addr;
    logic [CNT_W-1:0]  rd_iter;     // iter of the next read
    logic [CNT_W-1:0]  beat_iter;
    logic              beat_valid;
    logic              load_hit;
    logic              issue;
    logic              last_rd;
    logic              sram_en;
    logic              sram_we;
    logic [ADDR_W-1:0] sram_addr;
    logic [ID_W-1:0]   sram_rdata;

    assign load_hit = load.valid && (load.bank == BANK_W'(BANK_IDX));

    // read only when the beat slot is empty or drains this cycle
    assign issue   = (state == READ) && !load_hit && (!beat_valid || grant);
    assign last_rd = (rd_iter == req_q.count - 1'b1);

    // load write steals the port
    assign sram_en   = load_hit || issue;
    assign sram_we   = load_hit;
    assign sram_addr = load_hit ? load.addr : rd_addr;

    nbr_sram u_sram (
        .clk   (clk),
        .en    (sram_en),
        .we    (sram_we),
        .addr  (sram_addr),
        .wdata (load.id),
        .rdata (sram_rdata)
    );

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            req_q <= dispatch;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            rd_addr    <= '0;
            rd_iter    <= '0;
            beat_iter  <= '0;
            beat_valid <= 1'b0;
        end else begin
            if (issue) begin
                beat_valid <= 1'b1;
                beat_iter  <= rd_iter;
                rd_addr    <= rd_addr + 1'b1;
                rd_iter    <= rd_iter + 1'b1;
            end else if (grant) begin
                beat_valid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= READ;
                        rd_addr <= dispatch.start;
                        rd_iter <= '0;
                    end
                end
                READ: if (issue && last_rd) state <= HOLD;
                HOLD: if (grant && beat.eos) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // id comes straight off the sram output register
    always_comb begin
        beat.valid  = beat_valid;
        beat.sos    = (beat_iter == '0);
        beat.eos    = (beat_iter == req_q.count - 1'b1);
        beat.pe_tag = req_q.pe_tag;
        beat.iter   = beat_iter;
        beat.id     = sram_rdata;
    end

    assign busy = (state != IDLE);

    a_iter_range: assert property (@(posedge clk) disable iff (!rst_n)
        beat.valid |-> (beat.iter <= req_q.count - 1'b1))
        else $error("bank %0d iter past end of list", BANK_IDX);

    a_held_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (beat.valid && !grant) |=> $stable(beat))
        else $error("bank %0d beat changed while not granted", BANK_IDX);

endmodule

// ==== hw/nbr_sram.sv ====
`timescale 1ns/1ps

module nbr_sram (
    input  logic                       clk,
    input  logic                       en,
    input  logic                       we,
    input  logic [nbr_pkg::ADDR_W-1:0] addr,
    input  logic [nbr_pkg::ID_W-1:0]   wdata,
    output logic [nbr_pkg::ID_W-1:0]   rdata
);
    import nbr_pkg::*;

    logic [ID_W-1:0] mem [BANK_DEPTH];

    // single port, rdata holds its value on writes and idle cycles
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// ==== hw/nbr_mem_ctrl.sv ====
`timescale 1ns/1ps

module nbr_mem_ctrl (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  nbr_pkg::nbr_req_t                             head,
    input  logic                                          empty,
    input  logic [nbr_pkg::NUM_BANKS-1:0]                 bank_busy,
    output logic                                          pop,
    output nbr_pkg::nbr_req_t [nbr_pkg::NUM_BANKS-1:0]    dispatch,
    output logic [nbr_pkg::NUM_BANKS-1:0]                 start
);
    import nbr_pkg::*;

    logic [NUM_BANKS-1:0] bank_sel;
    logic                 head_free;

    always_comb begin
        bank_sel = '0;
        bank_sel[head.bank] = 1'b1;
    end

    // head blocks the queue until its own bank frees up
    assign head_free = !bank_busy[head.bank];
    assign pop       = !empty && head_free;
    assign start     = pop ? bank_sel : '0;

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            dispatch[b] = bank_sel[b] ? head : '0;
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_chk
        // started bank was idle and reports busy right after
        a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
            start[b] |-> !bank_busy[b] ##1 bank_busy[b])
            else $error("bank %0d started while busy", b);
    end

endmodule

// ==== hw/nbr_req_fifo.sv ====
`timescale 1ns/1ps

module nbr_req_fifo (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  nbr_pkg::nbr_req_t din,
    input  logic              pop,
    output nbr_pkg::nbr_req_t head,
    output logic              empty,
    output logic              full
);
    import nbr_pkg::*;

    nbr_req_t              mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic [FIFO_CNT_W-1:0] count_next;
    logic                  wr_en;
    logic                  rd_en;

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;
    assign head  = mem[rd_ptr];   // fall-through read of the oldest entry

    assign count_next = count + FIFO_CNT_W'(wr_en) - FIFO_CNT_W'(rd_en);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    // flags come from the next count so both are plain registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two, wraps
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            full  <= (count_next == FIFO_CNT_W'(FIFO_DEPTH));
            empty <= (count_next == '0);
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !full)
        else $error("request FIFO pushed while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty)
        else $error("request FIFO popped while empty");

endmodule

// ==== hw/nbr_pkg.sv ====
package nbr_pkg;

    localparam int NUM_BANKS  = 4;
    localparam int NUM_PE     = 4;
    localparam int BANK_DEPTH = 64;
    localparam int ADDR_W     = 6;
    localparam int ID_W       = 14;
    localparam int CNT_W      = 4;   // counts 1..15, never 0
    localparam int FIFO_DEPTH = 8;

    localparam int BANK_W     = $clog2(NUM_BANKS);
    localparam int PE_W       = $clog2(NUM_PE);
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

    // neighbor info for one edge PE request
    typedef struct packed {
        logic [BANK_W-1:0] bank;
        logic [ADDR_W-1:0] start;
        logic [CNT_W-1:0]  count;
        logic [PE_W-1:0]   pe_tag;
    } nbr_req_t;

    typedef struct packed {
        logic              valid;
        logic [BANK_W-1:0] bank;
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
    } nbr_load_t;

    // bank controller to bus
    typedef struct packed {
        logic              valid;
        logic              sos;
        logic              eos;
        logic [PE_W-1:0]   pe_tag;
        logic [CNT_W-1:0]  iter;
        logic [ID_W-1:0]   id;
    } bank_beat_t;

    typedef struct packed {
        logic              valid;
        logic              sos;
        logic              eos;
        logic [CNT_W-1:0]  iter;
        logic [ID_W-1:0]   id;
    } pe_stream_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        HOLD   // last read issued, waiting on eos grant
    } bank_state_e;

endpackage
